// ==== common/disk_defines.svh ====
`ifndef DISK_DEFINES_SVH
`define DISK_DEFINES_SVH

// ==============================
// Floppy track geometry
// ==============================

// Blocks of 512 bytes in one track
`define SECTORS_PER_TRACK 13

// Byte offset inside one SD block
`define BLOCK_ADDR_W 9

// Block index inside one track
`define SECTOR_IDX_W 4

// Track number from the drive
`define TRACK_W 6

// Byte address across a whole track
`define TRACK_ADDR_W 13

// ==============================
// SD card addressing
// ==============================
`define LBA_W 32

`endif

// ==== common/disk_pkg.sv ====
`default_nettype none

`include "disk_defines.svh"

package disk_pkg;

	// ==============================
	// Track addressing
	// ==============================

	// Sector index in the top bits, byte offset below
	typedef struct packed {
		logic [`SECTOR_IDX_W-1:0] sector;
		logic [`BLOCK_ADDR_W-1:0] offset;
	} sector_off_t;

	// One 13-bit word, seen flat by the drive
	// or split into sector and offset by the SD side
	typedef union packed {
		logic [`TRACK_ADDR_W-1:0] flat;
		sector_off_t              so;
	} track_addr_u;

	// Track number as reported by the drive
	typedef logic [`TRACK_W-1:0] track_t;

	// ==============================
	// Drive side of the track buffer
	// ==============================

	// Address, single-cycle write strobe and byte to write
	typedef struct packed {
		track_addr_u addr;
		logic        we;
		logic [7:0]  wdata;
	} drive_port_t;

	// Track sequencer FSM
	typedef enum logic [1:0] {
		SEQ_IDLE     = 2'b00,
		// Write-back of a dirty track
		SEQ_WRITE    = 2'b01,
		SEQ_RD_START = 2'b10,
		SEQ_READ     = 2'b11
	} seq_state_t;

endpackage

`default_nettype wire

// ==== common/sd_pkg.sv ====
`default_nettype none

`include "disk_defines.svh"

package sd_pkg;

	// ==============================
	// SD host block interface
	// ==============================

	// One channel's request, rd and wr are held levels
	typedef struct packed {
		logic             rd;
		logic             wr;
		logic [`LBA_W-1:0] lba;
	} sd_req_t;

	// Byte stream from the host during an acked block
	typedef struct packed {
		logic [`BLOCK_ADDR_W-1:0] addr;
		logic [7:0]               dout;
		// Strobe for dout into the block buffer
		logic                     wr;
	} sd_blk_t;

	// Image report, mounted is a single-cycle strobe
	// size and readonly are valid with it
	typedef struct packed {
		logic        mounted;
		logic        readonly;
		logic [63:0] size;
	} img_info_t;

endpackage

`default_nettype wire

// ==== floppy/track_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "disk_defines.svh"

module track_buffer
	import disk_pkg::*, sd_pkg::*;
(
	input  wire logic                     clk_sys,
	input  wire logic                     dd_reset,
	input  wire sd_blk_t                  sd_blk,
	input  wire logic                     sd_ack0,
	input  wire logic [`SECTOR_IDX_W-1:0] sd_sector,
	input  wire drive_port_t              drive,
	output logic [7:0]                    sd_buff_din,
	output logic [7:0]                    drive_rdata
);

	// One whole track of bytes
	logic [7:0] mem [0:`SECTORS_PER_TRACK*(1<<`BLOCK_ADDR_W)-1];

	track_addr_u addr_a;
	logic        we_a;
	logic        we_b;

	// SD side builds its address from the block being transferred
	assign addr_a.so.sector = sd_sector;
	assign addr_a.so.offset = sd_blk.addr;

	// Host bytes only land here while channel 0 is acked
	// No writes on either port while the drive is in reset
	assign we_a = sd_blk.wr & sd_ack0 & ~dd_reset;
	assign we_b = drive.we & ~dd_reset;

	// ==============================
	// Port A, SD host
	// ==============================
	always @(posedge clk_sys) begin
		if (we_a) begin
			mem[addr_a.flat] <= sd_blk.dout;
			// Write-through on the same port
			sd_buff_din <= sd_blk.dout;
		end else begin
			sd_buff_din <= mem[addr_a.flat];
		end
	end

	// ==============================
	// Port B, emulated drive
	// ==============================
	always @(posedge clk_sys) begin
		if (we_b) begin
			mem[drive.addr.flat] <= drive.wdata;
			drive_rdata <= drive.wdata;
		end else begin
			drive_rdata <= mem[drive.addr.flat];
		end
	end

endmodule

`default_nettype wire

// ==== floppy/track_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "disk_defines.svh"

module track_sequencer
	import disk_pkg::*, sd_pkg::*;
(
	input  wire logic                     clk_sys,
	input  wire logic                     dd_reset,
	input  wire track_t                   track,
	input  wire logic                     drive_wr,
	input  wire img_info_t                img,
	input  wire logic                     sd_ack0,
	output sd_req_t                       sd_req0,
	output logic [`SECTOR_IDX_W-1:0]      sd_sector,
	output logic                          cpu_wait_fdd
);

	seq_state_t         state;
	track_t             cur_track;
	logic               ack_d;
	logic               ack_rise;
	logic               ack_fall;
	logic               req_rd;
	logic               req_wr;
	logic [`LBA_W-1:0]  lba;
	// Buffer holds drive writes not yet on the card
	logic               dirty;
	// Mount of a nonempty image asks for the track again
	logic               reload;
	// Image status, kept across a drive reset
	logic               img_ok;
	logic               change;
	logic               last_sector;

	assign ack_rise = sd_ack0 & ~ack_d;
	assign ack_fall = ~sd_ack0 & ack_d;

	// Something to do only with a usable image
	assign change = ((cur_track != track) | reload) & img_ok;

	assign last_sector = (sd_sector == `SECTORS_PER_TRACK - 1);

	assign sd_req0.rd  = req_rd;
	assign sd_req0.wr  = req_wr;
	assign sd_req0.lba = lba;

	// ==============================
	// Image status latch
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (img.mounted) begin
			img_ok <= (img.size != 0);
		end
	end

	// ==============================
	// Track FSM
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			state        <= SEQ_IDLE;
			ack_d        <= 1'b0;
			req_rd       <= 1'b0;
			req_wr       <= 1'b0;
			cpu_wait_fdd <= 1'b0;
			dirty        <= 1'b0;
			reload       <= 1'b0;
			sd_sector    <= '0;
		end else begin
			ack_d <= sd_ack0;

			case (state)
				SEQ_IDLE: begin
					if (change) begin
						if (dirty) begin
							// Old track goes back to the card first
							dirty        <= 1'b0;
							sd_sector    <= '0;
							lba          <= `SECTORS_PER_TRACK * cur_track;
							req_wr       <= 1'b1;
							cpu_wait_fdd <= 1'b1;
							state        <= SEQ_WRITE;
						end else begin
							state <= SEQ_RD_START;
						end
					end
				end

				SEQ_WRITE: begin
					if (ack_rise) begin
						lba <= lba + 1'b1;
						// Host has taken the last request of the track
						if (last_sector) req_wr <= 1'b0;
					end else if (ack_fall) begin
						sd_sector <= sd_sector + 1'b1;
						if (!req_wr) state <= SEQ_RD_START;
					end
				end

				SEQ_RD_START: begin
					cur_track    <= track;
					reload       <= 1'b0;
					sd_sector    <= '0;
					lba          <= `SECTORS_PER_TRACK * track;
					req_rd       <= 1'b1;
					cpu_wait_fdd <= 1'b1;
					state        <= SEQ_READ;
				end

				SEQ_READ: begin
					if (ack_rise) begin
						lba <= lba + 1'b1;
						if (last_sector) req_rd <= 1'b0;
					end else if (ack_fall) begin
						sd_sector <= sd_sector + 1'b1;
						// CPU waits for the whole track, not per block
						if (!req_rd) begin
							cpu_wait_fdd <= 1'b0;
							state        <= SEQ_IDLE;
						end
					end
				end

				default: state <= SEQ_IDLE;
			endcase

			// Drive writes mark the cached track
			if (drive_wr) dirty <= 1'b1;

			// New image wins over everything
			// Old buffer contents never reach it
			if (img.mounted) begin
				dirty  <= 1'b0;
				reload <= (img.size != 0);
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdd/hdd_request.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "disk_defines.svh"

module hdd_request
	import sd_pkg::*;
(
	input  wire logic              clk_sys,
	input  wire logic              dd_reset,
	input  wire logic              hdd_read,
	input  wire logic              hdd_write,
	input  wire logic [`LBA_W-1:0] hdd_sector,
	input  wire img_info_t         img,
	input  wire logic              sd_ack1,
	output sd_req_t                sd_req1,
	output logic                   hdd_mounted,
	output logic                   hdd_protect,
	output logic                   cpu_wait_hdd
);

	// Low when waiting for a pending request
	logic busy;
	logic ack_d;
	logic ack_rise;
	logic ack_fall;
	logic rd_pending;
	logic wr_pending;
	logic req_rd;
	logic req_wr;

	assign ack_rise = sd_ack1 & ~ack_d;
	assign ack_fall = ~sd_ack1 & ack_d;

	// Sector number goes straight through to the host
	assign sd_req1.rd  = req_rd;
	assign sd_req1.wr  = req_wr;
	assign sd_req1.lba = hdd_sector;

	// ==============================
	// Mount status
	// ==============================
	// Survives a drive reset, only a new mount changes it
	always_ff @(posedge clk_sys) begin
		if (img.mounted) begin
			hdd_mounted <= (img.size != 0);
			hdd_protect <= img.readonly;
		end
	end

	// ==============================
	// Request handshake
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			busy         <= 1'b0;
			ack_d        <= 1'b0;
			rd_pending   <= 1'b0;
			wr_pending   <= 1'b0;
			req_rd       <= 1'b0;
			req_wr       <= 1'b0;
			cpu_wait_hdd <= 1'b0;
		end else begin
			ack_d <= sd_ack1;

			// Strobes collect here, a served one is cleared on ack rise
			rd_pending <= (rd_pending & ~(busy & ack_rise & req_rd)) | hdd_read;
			wr_pending <= (wr_pending & ~(busy & ack_rise & req_wr)) | hdd_write;

			if (!busy) begin
				if (rd_pending | wr_pending) begin
					busy         <= 1'b1;
					// Read first when both are waiting
					req_rd       <= rd_pending;
					req_wr       <= wr_pending & ~rd_pending;
					cpu_wait_hdd <= 1'b1;
				end
			end else if (ack_rise) begin
				req_rd <= 1'b0;
				req_wr <= 1'b0;
			end else if (ack_fall) begin
				busy         <= 1'b0;
				cpu_wait_hdd <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/disk_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "disk_defines.svh"

module disk_ctrl_top
	import disk_pkg::*, sd_pkg::*;
(
	input  wire logic              clk_sys,
	input  wire logic              dd_reset,

	// SD host
	input  wire logic [1:0]        sd_ack,
	input  wire sd_blk_t           sd_blk,
	input  wire img_info_t         img0,
	input  wire img_info_t         img1,
	output sd_req_t                sd_req0,
	output sd_req_t                sd_req1,
	output logic [7:0]             sd_buff_din0,

	// Emulated drive
	input  wire track_t            track,
	input  wire drive_port_t       drive,
	input  wire logic              hdd_read,
	input  wire logic              hdd_write,
	input  wire logic [`LBA_W-1:0] hdd_sector,
	output logic [7:0]             drive_rdata,
	output logic                   cpu_wait_fdd,
	output logic                   cpu_wait_hdd,
	output logic                   hdd_mounted,
	output logic                   hdd_protect
);

	// Block being moved on channel 0
	logic [`SECTOR_IDX_W-1:0] fdd_sector;

	// ==============================
	// Floppy, channel 0
	// ==============================
	track_buffer u_track_buffer (
		.clk_sys     (clk_sys),
		.dd_reset    (dd_reset),
		.sd_blk      (sd_blk),
		.sd_ack0     (sd_ack[0]),
		.sd_sector   (fdd_sector),
		.drive       (drive),
		.sd_buff_din (sd_buff_din0),
		.drive_rdata (drive_rdata)
	);

	track_sequencer u_track_sequencer (
		.clk_sys      (clk_sys),
		.dd_reset     (dd_reset),
		.track        (track),
		.drive_wr     (drive.we),
		.img          (img0),
		.sd_ack0      (sd_ack[0]),
		.sd_req0      (sd_req0),
		.sd_sector    (fdd_sector),
		.cpu_wait_fdd (cpu_wait_fdd)
	);

	// ==============================
	// Hard disk, channel 1
	// ==============================
	hdd_request u_hdd_request (
		.clk_sys      (clk_sys),
		.dd_reset     (dd_reset),
		.hdd_read     (hdd_read),
		.hdd_write    (hdd_write),
		.hdd_sector   (hdd_sector),
		.img          (img1),
		.sd_ack1      (sd_ack[1]),
		.sd_req1      (sd_req1),
		.hdd_mounted  (hdd_mounted),
		.hdd_protect  (hdd_protect),
		.cpu_wait_hdd (cpu_wait_hdd)
	);

endmodule

`default_nettype wire

// ==== tb/disk_ctrl_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module disk_ctrl_properties
	import sd_pkg::*;
(
	input wire logic    clk_sys,
	input wire logic    dd_reset,
	input wire sd_req_t sd_req0,
	input wire sd_req_t sd_req1,
	input wire logic    cpu_wait_fdd,
	input wire logic    cpu_wait_hdd
);

	// Number of failed protocol checks, read by the testbench
	int unsigned fail_count = 0;

	// ==============================
	// Request levels
	// ==============================

	// A channel never asks for read and write at once
	fdd_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (dd_reset)
		!(sd_req0.rd && sd_req0.wr))
	else begin
		$error("Floppy channel requests read and write together");
		fail_count++;
	end

	hdd_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (dd_reset)
		!(sd_req1.rd && sd_req1.wr))
	else begin
		$error("Hard disk channel requests read and write together");
		fail_count++;
	end

	// CPU is held for as long as the floppy channel has a request up
	fdd_wait_covers_request: assert property (@(posedge clk_sys) disable iff (dd_reset)
		(sd_req0.rd || sd_req0.wr) |-> cpu_wait_fdd)
	else begin
		$error("Floppy request is high without the CPU wait flag");
		fail_count++;
	end

	// ==============================
	// Reset values
	// ==============================
	quiet_after_reset: assert property (@(posedge clk_sys)
		dd_reset |=> (!sd_req0.rd && !sd_req0.wr && !sd_req1.rd && !sd_req1.wr
			&& !cpu_wait_fdd && !cpu_wait_hdd))
	else begin
		$error("Requests or wait flags are high in the cycle after reset");
		fail_count++;
	end

endmodule

bind disk_ctrl_top disk_ctrl_properties u_props (
	.clk_sys      (clk_sys),
	.dd_reset     (dd_reset),
	.sd_req0      (sd_req0),
	.sd_req1      (sd_req1),
	.cpu_wait_fdd (cpu_wait_fdd),
	.cpu_wait_hdd (cpu_wait_hdd)
);

`default_nettype wire

// ==== tb/disk_ctrl_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "disk_defines.svh"

module disk_ctrl_tb
	import disk_pkg::*, sd_pkg::*;
;

	localparam int TRACK_BYTES = `SECTORS_PER_TRACK * (1 << `BLOCK_ADDR_W);
	localparam int BLOCK_BYTES = 1 << `BLOCK_ADDR_W;
	localparam int WAIT_LIMIT  = 2000;
	// Right-shift Galois form of x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic              clk_sys;
	logic              dd_reset;
	logic [1:0]        sd_ack;
	sd_blk_t           sd_blk;
	img_info_t         img0;
	img_info_t         img1;
	sd_req_t           sd_req0;
	sd_req_t           sd_req1;
	logic [7:0]        sd_buff_din0;
	track_t            track;
	drive_port_t       drive;
	logic              hdd_read;
	logic              hdd_write;
	logic [`LBA_W-1:0] hdd_sector;
	logic [7:0]        drive_rdata;
	logic              cpu_wait_fdd;
	logic              cpu_wait_hdd;
	logic              hdd_mounted;
	logic              hdd_protect;

	logic [31:0] lfsr_state;
	// Expected contents of the cached track
	logic [7:0]  shadow [0:TRACK_BYTES-1];
	int          i;
	int          addr;
	logic [7:0]  rdata;
	logic [7:0]  wbyte;

	disk_ctrl_top u_dut (.*);

	always #50 clk_sys = ~clk_sys;

	// ==============================
	// Failure reporting
	// ==============================
	task stop_with_failure();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task report_mismatch(input string test, input logic [31:0] expected, input logic [31:0] actual);
		$display("CHECK FAILED %s expected 0x%0h actual 0x%0h", test, expected, actual);
		stop_with_failure();
	endtask

	task report_timeout(input string what);
		$display("Timeout while waiting: %s", what);
		stop_with_failure();
	endtask

	// Bound protocol checker
	always @(negedge clk_sys) begin
		if (u_dut.u_props.fail_count != 0) begin
			$display("A bound protocol assertion failed");
			stop_with_failure();
		end
	end

	// ==============================
	// Stimulus helpers
	// ==============================

	// One LFSR step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		int          b;
		v = '0;
		for (b = 0; b < n; b++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
		end
		return v;
	endfunction

	// Host image data: low LBA byte xor low offset byte
	function automatic logic [7:0] host_byte(input logic [31:0] lba, input int k);
		return lba[7:0] ^ k[7:0];
	endfunction

	task automatic mount_image(input bit hdd, input bit ro, input logic [63:0] size);
		@(posedge clk_sys);
		if (hdd) img1 <= '{mounted: 1'b1, readonly: ro, size: size};
		else img0 <= '{mounted: 1'b1, readonly: ro, size: size};
		@(posedge clk_sys);
		img0.mounted <= 1'b0;
		img1.mounted <= 1'b0;
	endtask

	task automatic write_drive(input int a, input logic [7:0] d);
		@(posedge clk_sys);
		drive.addr.flat <= 13'(a);
		drive.wdata     <= d;
		drive.we        <= 1'b1;
		@(posedge clk_sys);
		drive.we <= 1'b0;
	endtask

	// Data shows one cycle after the address
	task automatic read_drive(input int a, output logic [7:0] d);
		@(posedge clk_sys);
		drive.addr.flat <= 13'(a);
		drive.we        <= 1'b0;
		@(posedge clk_sys);
		@(posedge clk_sys);
		d = drive_rdata;
	endtask

	task automatic wait_fdd_request(input string test);
		int   n;
		logic seen;
		seen = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !seen; n++) begin
			@(posedge clk_sys);
			seen = sd_req0.rd | sd_req0.wr;
		end
		if (!seen) report_timeout({test, ", no request on the floppy channel"});
	endtask

	task automatic wait_cpu_release(input bit hdd, input string test);
		int   n;
		logic done;
		done = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !done; n++) begin
			@(posedge clk_sys);
			done = hdd ? !cpu_wait_hdd : !cpu_wait_fdd;
		end
		if (!done) report_timeout({test, ", CPU wait flag never dropped"});
	endtask

	// ==============================
	// SD host model, floppy channel
	// ==============================
	task automatic serve_read_block(input logic [31:0] exp_lba, input string test);
		int k;
		wait_fdd_request(test);
		assert (sd_req0.rd && !sd_req0.wr) else report_mismatch(test, 2'b10, {sd_req0.rd, sd_req0.wr});
		assert (sd_req0.lba == exp_lba) else report_mismatch(test, exp_lba, sd_req0.lba);
		assert (cpu_wait_fdd) else report_mismatch(test, 1, cpu_wait_fdd);
		repeat (random_bits(3) + 2) begin
			@(posedge clk_sys);
			// Wait flag holds across the gap between blocks
			assert (cpu_wait_fdd) else report_mismatch(test, 1, cpu_wait_fdd);
		end
		sd_ack[0] <= 1'b1;
		for (k = 0; k < BLOCK_BYTES; k++) begin
			@(posedge clk_sys);
			sd_blk.addr <= 9'(k);
			sd_blk.dout <= host_byte(exp_lba, k);
			sd_blk.wr   <= 1'b1;
		end
		@(posedge clk_sys);
		// Still waiting right up to the end of the block
		assert (cpu_wait_fdd) else report_mismatch(test, 1, cpu_wait_fdd);
		sd_blk.wr <= 1'b0;
		sd_ack[0] <= 1'b0;
	endtask

	// Capture runs two edges behind the address
	task automatic serve_write_block(input logic [31:0] exp_lba, input int sector, input string test);
		int         k;
		logic [7:0] expected;
		wait_fdd_request(test);
		assert (sd_req0.wr && !sd_req0.rd) else report_mismatch(test, 2'b01, {sd_req0.rd, sd_req0.wr});
		assert (sd_req0.lba == exp_lba) else report_mismatch(test, exp_lba, sd_req0.lba);
		assert (cpu_wait_fdd) else report_mismatch(test, 1, cpu_wait_fdd);
		repeat (random_bits(3) + 2) begin
			@(posedge clk_sys);
			assert (cpu_wait_fdd) else report_mismatch(test, 1, cpu_wait_fdd);
		end
		sd_ack[0] <= 1'b1;
		for (k = 0; k < BLOCK_BYTES + 2; k++) begin
			@(posedge clk_sys);
			if (k >= 2) begin
				expected = shadow[sector * BLOCK_BYTES + k - 2];
				assert (sd_buff_din0 == expected) else report_mismatch(test, expected, sd_buff_din0);
			end
			if (k < BLOCK_BYTES) sd_blk.addr <= 9'(k);
		end
		sd_ack[0] <= 1'b0;
	endtask

	task automatic run_track_read(input logic [31:0] base, input string test);
		int s;
		for (s = 0; s < `SECTORS_PER_TRACK; s++) begin
			serve_read_block(base + s, test);
		end
		assert (!sd_req0.rd) else report_mismatch(test, 0, sd_req0.rd);
		wait_cpu_release(1'b0, test);
		for (s = 0; s < TRACK_BYTES; s++) begin
			shadow[s] = host_byte(base + s / BLOCK_BYTES, s % BLOCK_BYTES);
		end
	endtask

	// ==============================
	// SD host model, hard disk channel
	// ==============================
	task automatic serve_hdd(input bit is_write, input string test);
		logic [31:0] sector;
		int          n;
		logic        seen;
		sector = random_bits(32);
		@(posedge clk_sys);
		hdd_sector <= sector;
		hdd_read   <= !is_write;
		hdd_write  <= is_write;
		@(posedge clk_sys);
		hdd_read  <= 1'b0;
		hdd_write <= 1'b0;
		seen = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !seen; n++) begin
			@(posedge clk_sys);
			seen = sd_req1.rd | sd_req1.wr;
		end
		if (!seen) report_timeout({test, ", no request on the hard disk channel"});
		assert (sd_req1.wr == is_write && sd_req1.rd == !is_write)
			else report_mismatch(test, {!is_write, is_write}, {sd_req1.rd, sd_req1.wr});
		assert (sd_req1.lba == sector) else report_mismatch(test, sector, sd_req1.lba);
		assert (cpu_wait_hdd) else report_mismatch(test, 1, cpu_wait_hdd);
		repeat (random_bits(3) + 2) @(posedge clk_sys);
		sd_ack[1] <= 1'b1;
		repeat (random_bits(4) + 4) begin
			@(posedge clk_sys);
			assert (cpu_wait_hdd) else report_mismatch(test, 1, cpu_wait_hdd);
		end
		// Request was taken on the ack rise
		assert (!sd_req1.rd && !sd_req1.wr) else report_mismatch(test, 0, {sd_req1.rd, sd_req1.wr});
		sd_ack[1] <= 1'b0;
		wait_cpu_release(1'b1, test);
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		clk_sys    = 1'b0;
		dd_reset   = 1'b1;
		sd_ack     = '0;
		sd_blk     = '0;
		img0       = '0;
		img1       = '0;
		track      = '0;
		drive      = '0;
		hdd_read   = 1'b0;
		hdd_write  = 1'b0;
		hdd_sector = '0;
		lfsr_state = 32'h127e_cc91;

		repeat (10) @(posedge clk_sys);
		dd_reset <= 1'b0;
		@(posedge clk_sys);

		// Everything quiet after reset
		assert (!sd_req0.rd && !sd_req0.wr && !sd_req1.rd && !sd_req1.wr)
			else report_mismatch("reset", 0, {sd_req0.rd, sd_req0.wr, sd_req1.rd, sd_req1.wr});
		assert (!cpu_wait_fdd && !cpu_wait_hdd)
			else report_mismatch("reset", 0, {cpu_wait_fdd, cpu_wait_hdd});

		// Clean load of track 5
		track <= 6'd5;
		mount_image(1'b0, 1'b0, 64'd143360);
		run_track_read(32'd65, "clean track change");
		for (i = 0; i < 16; i++) begin
			addr = random_bits(13) % TRACK_BYTES;
			read_drive(addr, rdata);
			assert (rdata == shadow[addr]) else report_mismatch("clean track change", shadow[addr], rdata);
		end

		// Dirty track goes back before track 7 comes in
		for (i = 0; i < 24; i++) begin
			addr  = random_bits(13) % TRACK_BYTES;
			wbyte = 8'(random_bits(8));
			write_drive(addr, wbyte);
			shadow[addr] = wbyte;
		end
		@(posedge clk_sys);
		track <= 6'd7;
		for (i = 0; i < `SECTORS_PER_TRACK; i++) begin
			serve_write_block(32'd65 + i, i, "dirty write-back");
		end
		assert (!sd_req0.wr) else report_mismatch("dirty write-back", 0, sd_req0.wr);
		run_track_read(32'd91, "dirty write-back");
		for (i = 0; i < 4; i++) begin
			addr = random_bits(13) % TRACK_BYTES;
			read_drive(addr, rdata);
			assert (rdata == shadow[addr]) else report_mismatch("dirty write-back", shadow[addr], rdata);
		end

		// Empty image, the sequencer must stay idle
		mount_image(1'b0, 1'b0, 64'd0);
		@(posedge clk_sys);
		track <= 6'd9;
		repeat (200) begin
			@(posedge clk_sys);
			assert (!sd_req0.rd && !sd_req0.wr && !cpu_wait_fdd)
				else report_mismatch("empty image", 0, {sd_req0.rd, sd_req0.wr, cpu_wait_fdd});
		end

		// Hard disk mount, then one read and one write
		mount_image(1'b1, 1'b1, 64'd1048576);
		repeat (2) @(posedge clk_sys);
		assert (hdd_mounted && hdd_protect)
			else report_mismatch("hard disk mount", 2'b11, {hdd_mounted, hdd_protect});
		serve_hdd(1'b0, "hard disk read");
		serve_hdd(1'b1, "hard disk write");

		@(posedge clk_sys);
		if (u_dut.u_props.fail_count != 0) begin
			$display("A bound protocol assertion failed");
			$display("Finished with errors");
			$fatal(1);
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
common/disk_pkg.sv
common/sd_pkg.sv
floppy/track_buffer.sv
floppy/track_sequencer.sv
hdd/hdd_request.sv
hdl/disk_ctrl_top.sv
tb/disk_ctrl_properties.sv
tb/disk_ctrl_tb.sv
